/* build.f */
hdl/spi_pkg.sv
hdl/spi_cmd_queue.sv
hdl/spi_sclk_gen.sv
hdl/spi_master.sv
hdl/spi_host_top.sv
verification/tb_spi_host.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --top-module tb_spi_host -f build.f -o tb_spi_host
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_spi_host > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -q "Something failed" "$log"
status=$?
if [ $status -eq 0 ]; then
  echo "Simulation reported a failure"
  exit 1
elif [ $status -ne 1 ]; then
  echo "Could not search $log"
  exit 1
fi
echo "Simulation passed"
exit 0

/* verification/spi_patterns.txt */
// Header: step count, then initial values of slave registers 0 to 7
// Steps: command (op, addr, data), expected read byte, burst flag
16
3c a5 0f f0 5a 96 c3 7e
// Single frames
000 3c 0
500 96 0
b12 00 0
300 12 0
fe1 00 0
700 e1 0
// Burst long enough to fill the queue
901 00 1
a02 00 1
100 01 1
c44 00 1
200 02 1
600 c3 1
9ff 00 1
100 ff 0
// Single frames
880 00 0
000 80 0
400 44 0
// Short burst on one register
daa 00 1
500 aa 1
d55 00 1
500 55 1
300 12 0

/* verification/tb_spi_host.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_host;

  localparam int q_depth      = 4;
  localparam int hdr_words    = 9;
  localparam int pat_words    = 128;
  localparam int rand_cmds    = 24;
  localparam int rdy_timeout  = 400;
  localparam int idle_timeout = 2000;

  logic        clk;
  logic        r_;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        miso;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        read_vld;
  logic [7:0]  read_data;

  // Step count, register table, then three words per step
  logic [15:0] pat [0:pat_words-1];

  // Host side
  logic [7:0]  model_regs [0:7];
  logic [7:0]  exp_read_mem [0:255];
  int          reads_pushed;
  int          pushed_cnt;
  int unsigned seq_errors;

  // Slave model and bus monitor
  logic [7:0]  slave_regs [0:7];
  logic [11:0] accept_mem [0:255];
  int          accepted_cnt;
  int          started_cnt;
  int          frames_done;
  int          read_strobes;
  int          full_falls;
  int unsigned mon_errors;
  int          rise_cnt;
  logic [11:0] rx_bits;
  logic [7:0]  miso_byte;
  logic        frame_write;
  logic        miso_next;
  logic        prev_cs;
  logic        prev_sclk;
  logic        prev_rdy;

  spi_host_top uut (
    .clk       (clk),
    .r_        (r_),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected, inout int unsigned err_cnt);
    if (got !== expected)
    begin
      err_cnt++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $finish;
  endtask

  task automatic push_cmd(input logic [11:0] cmd, input logic [7:0] exp_byte);
    int waited;
    waited  = 0;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy && waited < rdy_timeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_rdy)
      abort_run("Timeout: cmd_rdy stayed low, command not accepted");
    else
    begin
      if (cmd[11])
        model_regs[cmd[10:8]] = cmd[7:0];
      else
      begin
        exp_read_mem[reads_pushed] = exp_byte;
        reads_pushed++;
      end
      pushed_cnt++;
      // Transfer happens on the coming rising edge
      @(negedge clk);
      cmd_vld = 1'b0;
    end
  endtask

  task automatic wait_frames_done();
    int waited;
    waited = 0;
    while (frames_done != pushed_cnt && waited < idle_timeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (frames_done != pushed_cnt)
      abort_run("Timeout: pushed commands did not all finish as SPI frames");
  endtask

  // Slave output changes between clock edges
  initial
  begin
    miso = 1'b0;
    forever
    begin
      @(negedge clk);
      miso = miso_next;
    end
  end

  always @(posedge clk)
  begin : bus_monitor
    logic        frame_end;
    logic        exp_vld;
    logic        exp_rdy;
    logic [11:0] exp_frame;
    if (!r_)
    begin
      for (int i = 0; i < 8; i++)
        slave_regs[i] = pat[1 + i][7:0];
      accepted_cnt = 0;
      started_cnt  = 0;
      frames_done  = 0;
      read_strobes = 0;
      full_falls   = 0;
      mon_errors   = 0;
      rise_cnt     = 0;
      rx_bits      = '0;
      miso_byte    = '0;
      frame_write  = 1'b0;
      miso_next    = 1'b0;
      prev_cs      = 1'b1;
      prev_sclk    = 1'b0;
      prev_rdy     = 1'b1;
    end
    else
    begin
      frame_end = !prev_cs && cs;
      exp_vld   = 1'b0;
      if (prev_cs && !cs)
      begin
        rise_cnt    = 0;
        rx_bits     = '0;
        frame_write = 1'b0;
        started_cnt++;
      end
      // Mode 0, slave samples on rising SCLK
      if (!cs && sclk && !prev_sclk)
      begin
        rx_bits = {rx_bits[10:0], mosi};
        rise_cnt++;
        if (rise_cnt == 4)
        begin
          frame_write = rx_bits[3];
          miso_byte   = slave_regs[rx_bits[2:0]];
        end
      end
      if (!cs && !sclk && prev_sclk && !frame_write && rise_cnt >= 4 && rise_cnt < 12)
        miso_next = miso_byte[11 - rise_cnt];
      if (cs)
        check_value("sclk", 32'(sclk), 32'd0, mon_errors);
      if (frame_end)
      begin
        check_value("sclk rises in frame", 32'(rise_cnt), 32'd12, mon_errors);
        check_value("frame has accepted command", 32'(frames_done < accepted_cnt), 32'd1,
                    mon_errors);
        exp_frame = accept_mem[frames_done];
        // Master sends zeros in the data field of a read
        if (!exp_frame[11])
          exp_frame[7:0] = 8'h00;
        check_value("mosi frame bits", 32'(rx_bits), 32'(exp_frame), mon_errors);
        if (rx_bits[11])
          slave_regs[rx_bits[10:8]] = rx_bits[7:0];
        exp_vld   = !rx_bits[11];
        miso_next = 1'b0;
        frames_done++;
      end
      check_value("read_vld", 32'(read_vld), 32'(exp_vld), mon_errors);
      if (read_vld)
      begin
        check_value("read_data", 32'(read_data), 32'(exp_read_mem[read_strobes]), mon_errors);
        check_value("read_data from slave", 32'(read_data), 32'(miso_byte), mon_errors);
        read_strobes++;
      end
      exp_rdy = (accepted_cnt - started_cnt) != q_depth;
      check_value("cmd_rdy", 32'(cmd_rdy), 32'(exp_rdy), mon_errors);
      if (prev_rdy && !cmd_rdy)
        full_falls++;
      if (cmd_vld && cmd_rdy)
      begin
        accept_mem[accepted_cnt] = cmd_in;
        accepted_cnt++;
      end
      prev_cs   = cs;
      prev_sclk = sclk;
      prev_rdy  = cmd_rdy;
    end
  end

  initial
  begin : main_flow
    int unsigned seed_val;
    int          n_steps;
    int          base;
    logic [11:0] cmd;
    logic [7:0]  exp_byte;
    logic [31:0] rnd;
    seq_errors   = 0;
    reads_pushed = 0;
    pushed_cnt   = 0;
    r_           = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    seed_val     = $urandom(32'h556e9a9b);
    $readmemh("verification/spi_patterns.txt", pat);
    n_steps = int'(pat[0]);
    for (int i = 0; i < 8; i++)
      model_regs[i] = pat[1 + i][7:0];
    repeat (2) @(posedge clk);
    @(negedge clk);
    r_ = 1'b1;
    check_value("cs", 32'(cs), 32'd1, seq_errors);
    check_value("sclk", 32'(sclk), 32'd0, seq_errors);
    check_value("read_vld", 32'(read_vld), 32'd0, seq_errors);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1, seq_errors);
    if (n_steps == 0 || n_steps > (pat_words - hdr_words) / 3)
      abort_run("Pattern file is missing or its step count does not fit");
    else
    begin
      for (int s = 0; s < n_steps; s++)
      begin
        base     = hdr_words + 3 * s;
        cmd      = pat[base][11:0];
        exp_byte = pat[base + 1][7:0];
        if (!cmd[11])
          check_value("pattern read byte", 32'(exp_byte), 32'(model_regs[cmd[10:8]]),
                      seq_errors);
        push_cmd(cmd, exp_byte);
        if (!pat[base + 2][0])
          wait_frames_done();
      end
      // Random mix, read bytes expected from the host model
      for (int n = 0; n < rand_cmds; n++)
      begin
        rnd = $urandom;
        cmd = {rnd[0], rnd[3:1], rnd[11:4]};
        push_cmd(cmd, model_regs[cmd[10:8]]);
        if (!rnd[12])
          wait_frames_done();
      end
      wait_frames_done();
      check_value("read strobes", 32'(read_strobes), 32'(reads_pushed), seq_errors);
      check_value("cmd_rdy falls", 32'(full_falls != 0), 32'd1, seq_errors);
      $display("Frames: %0d, reads: %0d, sequence errors: %0d, monitor errors: %0d",
               frames_done, read_strobes, seq_errors, mon_errors);
      if (seq_errors + mon_errors == 0)
        $display("Everything OK");
      else
        $display("Something failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_host_top (
  input  logic                           clk,
  input  logic                           r_,
  input  logic [spi_pkg::cmd_width-1:0]  cmd_in,
  input  logic                           cmd_vld,
  input  logic                           miso,
  output logic                           cmd_rdy,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  output logic                           read_vld,
  output logic [spi_pkg::read_width-1:0] read_data
);
  import spi_pkg::*;

  // Queue to master
  logic [cmd_width-1:0] q_cmd;
  logic                 q_valid;
  logic                 q_pop;

  spi_cmd_queue u_cmd_queue (
    .clk     (clk),
    .r_      (r_),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .q_pop   (q_pop),
    .cmd_rdy (cmd_rdy),
    .q_cmd   (q_cmd),
    .q_valid (q_valid)
  );

  spi_master u_master (
    .clk       (clk),
    .r_        (r_),
    .q_cmd     (q_cmd),
    .q_valid   (q_valid),
    .miso      (miso),
    .q_pop     (q_pop),
    .cs        (cs),
    .mosi      (mosi),
    .sclk      (sclk),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  logic                           clk,
  input  logic                           r_,
  input  logic [spi_pkg::cmd_width-1:0]  q_cmd,
  input  logic                           q_valid,
  input  logic                           miso,
  output logic                           q_pop,
  output logic                           cs,
  output logic                           mosi,
  output logic                           sclk,
  output logic                           read_vld,
  output logic [spi_pkg::read_width-1:0] read_data
);
  import spi_pkg::*;

  master_state_t             state;
  master_state_t             state_nxt;
  spi_op_t                   cur_op;
  spi_op_t                   new_op;
  logic [cmd_width-1:0]      tx_shift;
  logic [read_width-1:0]     rx_shift;
  logic [edge_cnt_width-1:0] edge_cnt;
  logic [sclk_cnt_width-1:0] half_cnt;
  logic                      half_done;
  logic                      last_fall;
  logic                      sclk_en;
  logic                      sclk_rise;
  logic                      sclk_fall;

  spi_sclk_gen u_sclk_gen (
    .clk       (clk),
    .r_        (r_),
    .sclk_en   (sclk_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  assign new_op    = spi_op_t'(q_cmd[cmd_width-1]);
  assign half_done = (half_cnt == sclk_cnt_width'(sclk_half - 1));
  assign last_fall = sclk_fall && (edge_cnt == edge_cnt_width'(cmd_width));
  assign q_pop     = (state == st_idle) && q_valid;
  assign sclk_en   = (state == st_shift);
  assign mosi      = tx_shift[cmd_width-1];
  assign read_data = rx_shift;

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
        if (q_valid)
          state_nxt = st_setup;
      st_setup:
        if (half_done)
          state_nxt = st_shift;
      st_shift:
        if (last_fall)
          state_nxt = st_hold;
      st_hold:
        if (half_done)
          state_nxt = st_gap;
      st_gap:
        if (half_done)
          state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge r_)
  begin
    if (!r_)
    begin
      state    <= st_idle;
      half_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      // Shared by setup, hold and gap
      if (state_nxt != state)
        half_cnt <= '0;
      else if (state == st_setup || state == st_hold || state == st_gap)
        half_cnt <= half_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge r_)
  begin
    if (!r_)
    begin
      cs       <= 1'b1;
      cur_op   <= op_read;
      tx_shift <= '0;
      edge_cnt <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      if (q_pop)
      begin
        cs       <= 1'b0;
        cur_op   <= new_op;
        edge_cnt <= '0;
        // Reads send opcode and address, data field zeroed
        if (new_op == op_read)
          tx_shift <= {q_cmd[cmd_width-1 -: 1 + addr_width], read_width'(0)};
        else
          tx_shift <= q_cmd;
      end
      else if (state == st_shift)
      begin
        if (sclk_rise)
          edge_cnt <= edge_cnt + 1'b1;
        // Zeros fill in, so mosi idles low after the frame
        if (sclk_fall)
          tx_shift <= {tx_shift[cmd_width-2:0], 1'b0};
      end
      else if (state == st_hold && half_done)
      begin
        cs       <= 1'b1;
        read_vld <= (cur_op == op_read);
      end
    end
  end

  // Last read_width samples of a read frame
  always_ff @(posedge clk)
  begin
    if (state == st_shift && sclk_rise && cur_op == op_read &&
        edge_cnt >= edge_cnt_width'(cmd_width - read_width))
      rx_shift <= {rx_shift[read_width-2:0], miso};
  end

  a_sclk_low_when_deselected: assert property (
    @(posedge clk) disable iff (!r_) cs |-> !sclk
  ) else $error("spi_master: sclk high while cs is high");

  // A full read frame of cmd_width rising edges must precede the strobe
  a_read_vld_after_read: assert property (
    @(posedge clk) disable iff (!r_)
      read_vld |-> (edge_cnt == edge_cnt_width'(cmd_width)) && !$past(sclk) &&
                   (cur_op == op_read)
  ) else $error("spi_master: read_vld outside a read frame end");

endmodule

`default_nettype wire

/* hdl/spi_sclk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen (
  input  logic clk,
  input  logic r_,
  input  logic sclk_en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);
  import spi_pkg::*;

  logic [sclk_cnt_width-1:0] half_cnt;
  logic                      toggle;

  // End of a half period
  assign toggle = sclk_en && (half_cnt == sclk_cnt_width'(sclk_half - 1));

  always_ff @(posedge clk or negedge r_)
  begin
    if (!r_)
    begin
      half_cnt  <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      // Strobes line up with the new sclk level
      sclk_rise <= toggle && !sclk;
      sclk_fall <= toggle && sclk;
      if (!sclk_en)
      begin
        // Known phase for the next frame
        half_cnt <= '0;
        sclk     <= 1'b0;
      end
      else if (toggle)
      begin
        half_cnt <= '0;
        sclk     <= !sclk;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_queue (
  input  logic                          clk,
  input  logic                          r_,
  input  logic [spi_pkg::cmd_width-1:0] cmd_in,
  input  logic                          cmd_vld,
  input  logic                          q_pop,
  output logic                          cmd_rdy,
  output logic [spi_pkg::cmd_width-1:0] q_cmd,
  output logic                          q_valid
);
  import spi_pkg::*;

  logic [cmd_width-1:0]   mem [queue_depth];
  logic [q_ptr_width-1:0] wr_ptr;
  logic [q_ptr_width-1:0] rd_ptr;
  logic [q_cnt_width-1:0] count;
  logic                   push;

  function automatic logic [q_ptr_width-1:0] next_ptr(input logic [q_ptr_width-1:0] ptr);
    if (ptr == q_ptr_width'(queue_depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign push    = cmd_vld && cmd_rdy;
  assign cmd_rdy = (count != q_cnt_width'(queue_depth));
  assign q_valid = (count != '0);
  // Oldest entry always on the output
  assign q_cmd   = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= cmd_in;
  end

  always_ff @(posedge clk or negedge r_)
  begin
    if (!r_)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (q_pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, q_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Master must only pop what is there
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!r_) q_pop |-> (count != '0)
  ) else $error("spi_cmd_queue: pop while empty");

  a_count_in_range: assert property (
    @(posedge clk) disable iff (!r_) count <= q_cnt_width'(queue_depth)
  ) else $error("spi_cmd_queue: count above depth");

endmodule

`default_nettype wire

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // Frame format
  localparam int cmd_width  = 12;
  localparam int read_width = 8;
  localparam int addr_width = 3;

  // SCLK timing in clk cycles
  localparam int sclk_half = 4;

  // Host command buffering
  localparam int queue_depth = 4;

  // Derived counter widths
  localparam int sclk_cnt_width = (sclk_half > 1) ? $clog2(sclk_half) : 1;
  localparam int edge_cnt_width = $clog2(cmd_width + 1);
  localparam int q_ptr_width    = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int q_cnt_width    = $clog2(queue_depth + 1);

  // Command bit 11
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_t;

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_shift,
    st_hold,
    st_gap
  } master_state_t;

endpackage

`default_nettype wire
